// ==== hdl/fdd_my_pkg.sv ====
//**********************************************************
// shared constants, state encodings and bundles for the
// MY floppy host side, compiled ahead of every module
//**********************************************************
package fdd_my_pkg;

   // register select, wb_adr_i[1]
   localparam logic CSR_ADR = 1'b0;   // control/status
   localparam logic DR_ADR  = 1'b1;   // data register

   // csr bit positions
   localparam int CSR_GO_BIT   = 0;
   localparam int CSR_CMD_LSB  = 1;    // 4-bit command code
   localparam int CSR_DONE_BIT = 5;
   localparam int CSR_IE_BIT   = 6;
   localparam int CSR_DRQ_BIT  = 7;
   localparam int CSR_EXT_LSB  = 8;    // 6-bit address extension
   localparam int CSR_SRST_BIT = 14;
   localparam int CSR_ERR_BIT  = 15;

   // command codes
   localparam logic [3:0] CMD_RD     = 4'd0;
   localparam logic [3:0] CMD_WR     = 4'd1;
   localparam logic [3:0] CMD_RMD    = 4'd2;
   localparam logic [3:0] CMD_WRM    = 4'd3;
   localparam logic [3:0] CMD_RDID   = 4'd5;
   localparam logic [3:0] CMD_FORMAT = 4'd6;
   localparam logic [3:0] CMD_SEEK   = 4'd7;
   localparam logic [3:0] CMD_SET    = 4'd8;

   // image geometry
   localparam logic [6:0] MAX_CYL = 7'd79;
   localparam logic [3:0] MAX_SEC = 4'd9;   // sector numbers kept zero-based
   localparam int SEC_PER_TRK = 10;
   localparam int HEADS       = 2;

   // parameter block fetch
   localparam logic [7:0] DMA_TIMEOUT = 8'd200;                  // cycles per word
   localparam logic [1:0][1:0] PARM_WORD_OFS = {2'd2, 2'd0};     // [0] drv/hd, [1] cyl/sec

   typedef enum logic [2:0] {
      CMD_IDLE,
      CMD_WAITDATA,   // drq up, waiting for parm address
      CMD_FETCH,      // kick the dma fetch
      CMD_CHECK,      // wait for words, range check
      CMD_WAITDR      // non-transfer commands
   } cmd_state_t;

   typedef enum logic [1:0] {
      I_IDLE,
      I_REQ,          // irq asserted
      I_WAIT          // waiting for iack release
   } irq_state_t;

   typedef struct packed {
      logic [1:0] drive;
      logic       head;
      logic [6:0] cyl;
      logic [3:0] sec;
   } parm_t;

   typedef struct packed {
      logic err_cyl;
      logic err_sec;
      logic nxp;       // dma timeout
      logic spare;     // always 0
   } err_t;

   typedef struct packed {
      logic       go;
      logic [3:0] cmd;
   } cmd_req_t;

   typedef struct packed {
      logic       stb;
      err_t       err;
      logic [1:0] drive;
      logic       head;
   } finish_t;

endpackage

// ==== hdl/fdd_my_regs.sv ====
//**********************************************************
// wishbone slave for the csr and data registers, holds the
// status flags and runs the interrupt request machine
//**********************************************************
`timescale 1ns/1ps

module fdd_my_regs import fdd_my_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [1:0]  wb_adr_i,
   input  logic [15:0] wb_dat_i,
   output logic [15:0] wb_dat_o,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [1:0]  wb_sel_i,
   output logic        wb_ack_o,
   output logic        irq_o,
   input  logic        iack_i,
   input  logic        drq_set_i,
   input  finish_t     finish_i,
   output cmd_req_t    cmd_req_o,
   output logic        dr_wr_o,
   output logic [14:0] parm_addr_o,
   output logic [5:0]  extadr_o,
   output logic        srst_o
);

   logic        bus_rd, bus_wr;
   logic        wr_csr, wr_dr;
   logic        done, ie, drq;
   logic        irq_pend;          // finish seen, irq not yet raised
   irq_state_t  irq_state;
   err_t        err;
   logic [1:0]  drive;             // drive/head of last command
   logic        head;
   logic [15:0] csr_word, status;

   // one access per ack, ack blocks the next cycle
   assign bus_rd = wb_cyc_i & wb_stb_i & ~wb_we_i & ~wb_ack_o;
   assign bus_wr = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;
   assign wr_csr = bus_wr & (wb_adr_i[1] == CSR_ADR);
   assign wr_dr  = bus_wr & (wb_adr_i[1] == DR_ADR) & drq;   // only while drq

   // error/status word seen on dr when drq is low
   assign status = {4'b0000, err.nxp, head, drive, 2'b00, err.err_sec, err.err_cyl, 4'b0100};

   always_comb begin
      csr_word = '0;
      csr_word[CSR_DONE_BIT] = done;
      csr_word[CSR_IE_BIT]   = ie;
      csr_word[CSR_DRQ_BIT]  = drq;
      csr_word[CSR_ERR_BIT]  = err.err_cyl | err.err_sec | err.nxp;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) wb_ack_o <= 1'b0;
      else          wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
   end

   // read data and parameter block address
   always_ff @(posedge wb_clk_i) begin
      if (bus_rd) begin
         if (wb_adr_i[1] == CSR_ADR) wb_dat_o <= csr_word;
         else                        wb_dat_o <= drq ? 16'h0000 : status;
      end
      if (wr_dr & wb_sel_i[0]) parm_addr_o[6:0]  <= wb_dat_i[7:1];    // word address
      if (wr_dr & wb_sel_i[1]) parm_addr_o[14:7] <= wb_dat_i[15:8];
   end

   //**********************************************************
   // control flags and interrupt machine
   //**********************************************************
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         done      <= 1'b1;
         ie        <= 1'b0;
         drq       <= 1'b0;
         extadr_o  <= '0;
         err       <= '0;
         drive     <= '0;
         head      <= 1'b0;
         irq_pend  <= 1'b0;
         irq_state <= I_IDLE;
         irq_o     <= 1'b0;
         cmd_req_o <= '0;
         dr_wr_o   <= 1'b0;
         srst_o    <= 1'b0;
      end else begin
         srst_o       <= wr_csr & wb_sel_i[1] & wb_dat_i[CSR_SRST_BIT];
         dr_wr_o      <= wr_dr;
         cmd_req_o.go <= 1'b0;
         if (srst_o) begin   // soft reset, same state as wb_rst_i
            done      <= 1'b1;
            ie        <= 1'b0;
            drq       <= 1'b0;
            extadr_o  <= '0;
            err       <= '0;
            drive     <= '0;
            head      <= 1'b0;
            irq_pend  <= 1'b0;
            irq_state <= I_IDLE;
            irq_o     <= 1'b0;
         end else begin
            if (wr_csr & wb_sel_i[0]) begin
               ie <= wb_dat_i[CSR_IE_BIT];   // ie writable any time
               if (wb_dat_i[CSR_GO_BIT] & done) begin   // go ignored while busy
                  cmd_req_o <= '{go: 1'b1, cmd: wb_dat_i[CSR_CMD_LSB +: 4]};
                  done      <= 1'b0;
                  drq       <= 1'b0;
                  err       <= '0;
                  irq_pend  <= 1'b0;   // drop stale request
               end
            end
            if (wr_csr & wb_sel_i[1]) extadr_o <= wb_dat_i[CSR_EXT_LSB +: 6];

            if (wr_dr)          drq <= 1'b0;   // address taken
            else if (drq_set_i) drq <= 1'b1;

            if (finish_i.stb) begin
               done     <= 1'b1;
               err      <= finish_i.err;
               drive    <= finish_i.drive;
               head     <= finish_i.head;
               irq_pend <= 1'b1;
            end

            case (irq_state)
               I_IDLE:
                  if (ie & (irq_pend | finish_i.stb)) begin
                     irq_o     <= 1'b1;
                     irq_pend  <= 1'b0;
                     irq_state <= I_REQ;
                  end
               I_REQ:
                  if (~ie | iack_i) begin
                     irq_o     <= 1'b0;
                     irq_state <= ie ? I_WAIT : I_IDLE;   // ie cleared, just withdraw
                  end
               I_WAIT: if (~iack_i) irq_state <= I_IDLE;
               default: irq_state <= I_IDLE;
            endcase
         end
      end
   end

endmodule

// ==== hdl/fdd_my_parm_fetch.sv ====
//**********************************************************
// dma master reading words 0 and 2 of the parameter block
// from host memory, one timeout per word
//**********************************************************
`timescale 1ns/1ps

module fdd_my_parm_fetch import fdd_my_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        srst_i,
   input  logic        fetch_start_i,
   input  logic [14:0] parm_addr_i,
   input  logic [5:0]  extadr_i,
   output logic        dma_req_o,
   input  logic        dma_gnt_i,
   output logic [21:0] dma_adr_o,
   input  logic [15:0] dma_dat_i,
   output logic        dma_stb_o,
   output logic        dma_we_o,
   input  logic        dma_ack_i,
   output logic        fetch_done_o,
   output parm_t       parm_o,
   output logic        nxp_o
);

   logic       word_idx;   // 0 drive/head word, 1 cyl/sec word
   logic [7:0] timer;      // counts down while waiting for ack
   logic       take;       // word on the bus this cycle
   logic       launch;     // raise stb for the current word

   assign dma_we_o = 1'b0;   // host to controller only
   assign take     = dma_stb_o & dma_ack_i;
   assign launch   = dma_req_o & dma_gnt_i & ~dma_stb_o;

   // word address, byte address bit 0 forced low
   always_ff @(posedge wb_clk_i) begin
      if (launch)
         dma_adr_o <= {extadr_i, parm_addr_i + 15'(PARM_WORD_OFS[word_idx]), 1'b0};
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dma_req_o    <= 1'b0;
         dma_stb_o    <= 1'b0;
         word_idx     <= 1'b0;
         timer        <= '0;
         fetch_done_o <= 1'b0;
         nxp_o        <= 1'b0;
         parm_o       <= '0;
      end else if (srst_i) begin
         dma_req_o    <= 1'b0;
         dma_stb_o    <= 1'b0;
         word_idx     <= 1'b0;
         timer        <= '0;
         fetch_done_o <= 1'b0;
         nxp_o        <= 1'b0;
      end else begin
         fetch_done_o <= 1'b0;
         if (!dma_req_o) begin
            if (fetch_start_i) begin
               dma_req_o <= 1'b1;   // hold bus request for both words
               word_idx  <= 1'b0;
               timer     <= DMA_TIMEOUT;
               nxp_o     <= 1'b0;
            end
         end else if (take) begin
            dma_stb_o <= 1'b0;   // drop strobe after ack
            timer     <= DMA_TIMEOUT;
            word_idx  <= 1'b1;
            if (!word_idx) begin
               parm_o.drive <= dma_dat_i[1:0];
               parm_o.head  <= dma_dat_i[2];
            end else begin
               parm_o.cyl   <= dma_dat_i[14:8];
               parm_o.sec   <= dma_dat_i[3:0] - 4'd1;   // host counts from 1
               dma_req_o    <= 1'b0;
               fetch_done_o <= 1'b1;
            end
         end else if (timer == '0) begin
            // no answer, give up the bus
            dma_req_o    <= 1'b0;
            dma_stb_o    <= 1'b0;
            nxp_o        <= 1'b1;
            fetch_done_o <= 1'b1;
         end else begin
            timer <= timer - 8'd1;
            if (launch) dma_stb_o <= 1'b1;
         end
      end
   end

endmodule

// ==== hdl/fdd_my_cmd_ctl.sv ====
//**********************************************************
// command sequencer, checks the fetched parameters and
// works out the sd card block of the requested sector
//**********************************************************
`timescale 1ns/1ps

module fdd_my_cmd_ctl import fdd_my_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        srst_i,
   input  cmd_req_t    cmd_req_i,
   input  logic        dr_wr_i,
   input  logic        fetch_done_i,
   input  parm_t       parm_i,
   input  logic        nxp_i,
   input  logic [26:0] start_offset_i,
   output logic        drq_set_o,
   output logic        fetch_start_o,
   output finish_t     finish_o,
   output logic [26:0] sd_block_o
);

   cmd_state_t  state;
   logic        busy;
   err_t        chk_err;       // result of the range check
   logic [10:0] trk_ofs;       // cyl * 20
   logic [10:0] blk_ofs;       // block inside the disk image

   assign busy          = (state != CMD_IDLE);
   assign fetch_start_o = (state == CMD_FETCH);   // single cycle

   always_comb begin
      chk_err         = '0;
      chk_err.nxp     = nxp_i;
      chk_err.err_cyl = ~nxp_i & (parm_i.cyl > MAX_CYL);
      chk_err.err_sec = ~nxp_i & ~chk_err.err_cyl & (parm_i.sec > MAX_SEC);   // sector 0 wraps to 15
   end

   // cyl*20 + hd*10 + sec
   assign trk_ofs = 11'(parm_i.cyl) * 11'(SEC_PER_TRK * HEADS);
   assign blk_ofs = trk_ofs + (parm_i.head ? 11'(SEC_PER_TRK) : 11'd0) + 11'(parm_i.sec);

   always_ff @(posedge wb_clk_i) begin
      if (state == CMD_CHECK && fetch_done_i && chk_err == '0)
         sd_block_o <= {start_offset_i[26:13], parm_i.drive, blk_ofs};
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state     <= CMD_IDLE;
         drq_set_o <= 1'b0;
         finish_o  <= '0;
      end else if (srst_i) begin
         state     <= CMD_IDLE;
         drq_set_o <= 1'b0;
         finish_o  <= '0;
      end else begin
         drq_set_o    <= 1'b0;
         finish_o.stb <= 1'b0;
         if (cmd_req_i.go & ~busy) begin
            case (cmd_req_i.cmd)
               CMD_RD, CMD_WR, CMD_RMD, CMD_WRM: begin
                  drq_set_o <= 1'b1;   // ask host for parm address
                  state     <= CMD_WAITDATA;
               end
               CMD_RDID, CMD_FORMAT, CMD_SEEK, CMD_SET: begin
                  drq_set_o <= 1'b1;   // dr value is ignored
                  state     <= CMD_WAITDR;
               end
               default:   // nop, incl. read track and boot load
                  finish_o <= '{stb: 1'b1, err: '0, drive: parm_i.drive, head: parm_i.head};
            endcase
         end
         case (state)
            CMD_WAITDATA: if (dr_wr_i) state <= CMD_FETCH;
            CMD_FETCH:    state <= CMD_CHECK;
            CMD_CHECK:
               if (fetch_done_i) begin   // sector located or rejected
                  finish_o <= '{stb: 1'b1, err: chk_err, drive: parm_i.drive, head: parm_i.head};
                  state    <= CMD_IDLE;
               end
            CMD_WAITDR:
               if (dr_wr_i) begin
                  finish_o <= '{stb: 1'b1, err: '0, drive: parm_i.drive, head: parm_i.head};
                  state    <= CMD_IDLE;
               end
            default: ;
         endcase
      end
   end

endmodule

// ==== hdl/fdd_my_top.sv ====
//**********************************************************
// MY floppy controller host side, register slave, command
// sequencer and parameter fetch tied together
//**********************************************************
`timescale 1ns/1ps

module fdd_my_top import fdd_my_pkg::*; (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [1:0]  wb_adr_i,
   input  logic [15:0] wb_dat_i,
   output logic [15:0] wb_dat_o,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [1:0]  wb_sel_i,
   output logic        wb_ack_o,
   output logic        irq_o,
   input  logic        iack_i,
   output logic        dma_req_o,
   input  logic        dma_gnt_i,
   output logic [21:0] dma_adr_o,
   input  logic [15:0] dma_dat_i,
   output logic        dma_stb_o,
   output logic        dma_we_o,
   input  logic        dma_ack_i,
   input  logic [26:0] start_offset_i,   // image base on the card
   output logic [26:0] sd_block_o
);

   cmd_req_t    cmd_req;
   finish_t     finish;
   parm_t       parm;
   logic        dr_wr, drq_set, srst;
   logic        fetch_start, fetch_done, nxp;
   logic [14:0] parm_addr;
   logic [5:0]  extadr;

   fdd_my_regs fdd_my_regs_inst (
      .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_dat_o,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_sel_i, .wb_ack_o,
      .irq_o, .iack_i,
      .drq_set_i   (drq_set),
      .finish_i    (finish),
      .cmd_req_o   (cmd_req),
      .dr_wr_o     (dr_wr),
      .parm_addr_o (parm_addr),
      .extadr_o    (extadr),
      .srst_o      (srst)
   );

   fdd_my_parm_fetch fdd_my_parm_fetch_inst (
      .wb_clk_i, .wb_rst_i,
      .srst_i        (srst),
      .fetch_start_i (fetch_start),
      .parm_addr_i   (parm_addr),
      .extadr_i      (extadr),
      .dma_req_o, .dma_gnt_i, .dma_adr_o, .dma_dat_i,
      .dma_stb_o, .dma_we_o, .dma_ack_i,
      .fetch_done_o  (fetch_done),
      .parm_o        (parm),
      .nxp_o         (nxp)
   );

   fdd_my_cmd_ctl fdd_my_cmd_ctl_inst (
      .wb_clk_i, .wb_rst_i,
      .srst_i        (srst),
      .cmd_req_i     (cmd_req),
      .dr_wr_i       (dr_wr),
      .fetch_done_i  (fetch_done),
      .parm_i        (parm),
      .nxp_i         (nxp),
      .start_offset_i,
      .drq_set_o     (drq_set),
      .fetch_start_o (fetch_start),
      .finish_o      (finish),
      .sd_block_o
   );

endmodule

// ==== verification/fdd_my_assert.sv ====
//**********************************************************
// protocol assertions for the floppy host side, bound to
// the top level, failures counted for the testbench
//**********************************************************
`timescale 1ns/1ps

module fdd_my_assert (
   input logic wb_clk_i,
   input logic wb_rst_i,
   input logic ack_i,    // wishbone ack
   input logic irq_i,
   input logic ie_i,     // csr interrupt enable
   input logic req_i,    // dma request
   input logic gnt_i,
   input logic stb_i,
   input logic we_i
);

   int fail_cnt = 0;   // summed into the closing line

   // ack is a single cycle pulse
   ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ack_i |=> !ack_i)
      else begin
         $error("wishbone ack held high for two cycles");
         fail_cnt++;
      end

   // irq rises only when ie was set at the edge that raised it
   irq_needs_ie: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(irq_i) |-> $past(ie_i))
      else begin
         $error("irq raised while interrupts were disabled");
         fail_cnt++;
      end

   //**********************************************************
   // dma side
   //**********************************************************
   stb_in_grant: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_i |-> (req_i && gnt_i))
      else begin
         $error("dma strobe outside request and grant");
         fail_cnt++;
      end

   read_only: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !we_i)   // fetch never writes host memory
      else begin
         $error("dma write enable went high");
         fail_cnt++;
      end

endmodule

bind fdd_my_top fdd_my_assert fdd_my_assert_inst (
   .wb_clk_i (wb_clk_i),
   .wb_rst_i (wb_rst_i),
   .ack_i    (wb_ack_o),
   .irq_i    (irq_o),
   .ie_i     (fdd_my_regs_inst.ie),
   .req_i    (dma_req_o),
   .gnt_i    (dma_gnt_i),
   .stb_i    (dma_stb_o),
   .we_i     (dma_we_o)
);

// ==== verification/fdd_my_tb.sv ====
//**********************************************************
// directed testbench for the floppy host side, drives the
// wishbone slave and answers dma from a small memory model
//**********************************************************
`timescale 1ns/1ps

module fdd_my_tb import fdd_my_pkg::*; ();

   localparam logic [15:0] PARM_ADR = 16'h0040;   // byte address of the parm block
   localparam logic [5:0]  EXT_ADR  = 6'h01;
   localparam logic [1:0]  CSR      = {CSR_ADR, 1'b0};
   localparam logic [1:0]  DR       = {DR_ADR, 1'b0};

   logic        wb_clk_i, wb_rst_i;
   logic [1:0]  wb_adr_i;
   logic [15:0] wb_dat_i, wb_dat_o;
   logic        wb_cyc_i, wb_stb_i, wb_we_i;
   logic [1:0]  wb_sel_i;
   logic        wb_ack_o, irq_o, iack_i;
   logic        dma_req_o, dma_gnt_i, dma_stb_o, dma_we_o, dma_ack_i;
   logic [21:0] dma_adr_o;
   logic [15:0] dma_dat_i;
   logic [26:0] start_offset_i, sd_block_o;

   logic [15:0] mem [0:255];   // host memory, word indexed
   logic [21:0] adr_q [$];     // addresses acked by the model
   integer      seed = 35;
   int          errors, timeouts, req_cnt, irq_cnt, ack_wait;
   logic        no_ack, req_q, ack_busy;

   fdd_my_top fdd_my_top_inst (.*);

   initial begin
      wb_clk_i = 1'b0;
      forever #50 wb_clk_i = ~wb_clk_i;
   end

   //**********************************************************
   // dma memory model, grant trails request by one cycle
   //**********************************************************
   initial begin
      forever begin
         @(posedge wb_clk_i);
         #5;
         dma_ack_i = 1'b0;
         dma_gnt_i = req_q;
         req_q     = dma_req_o;
         if (dma_req_o) req_cnt++;
         if (irq_o) irq_cnt++;
         if (dma_stb_o && !ack_busy && !no_ack) begin
            ack_busy = 1'b1;
            ack_wait = $unsigned($random(seed)) % 4;   // 0..3 wait cycles
         end
         if (ack_busy) begin
            if (ack_wait == 0) begin
               dma_ack_i = 1'b1;
               dma_dat_i = mem[dma_adr_o[8:1]];
               adr_q.push_back(dma_adr_o);
               ack_busy  = 1'b0;
            end else begin
               ack_wait--;
            end
         end
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // one wishbone cycle, called 5 ns after a rising edge
   task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
                             output logic [15:0] rdat);
      int n;
      n        = 0;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      do begin
         @(posedge wb_clk_i);
         #5;
         n++;
      end while (!wb_ack_o && n < 20);
      if (!wb_ack_o) begin
         $display("timeout: no wishbone ack on register %0d", adr);
         timeouts++;
      end
      rdat     = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [1:0] adr, input logic [15:0] wdat);
      logic [15:0] unused_rd;
      bus_access(1'b1, adr, wdat, unused_rd);
   endtask

   task automatic bus_read(input logic [1:0] adr, output logic [15:0] rdat);
      bus_access(1'b0, adr, 16'h0000, rdat);
   endtask

   // read csr until one bit reaches the wanted level
   task automatic poll_csr(input int bit_no, input logic val, input string what);
      logic [15:0] csr;
      int n;
      n = 0;
      do begin
         bus_read(CSR, csr);
         n++;
      end while (csr[bit_no] !== val && n < 500);
      if (csr[bit_no] !== val) begin
         $display("timeout waiting for %s", what);
         timeouts++;
      end
   endtask

   task automatic wait_irq(input logic val);
      int n;
      n = 0;
      while (irq_o !== val && n < 50) begin
         @(posedge wb_clk_i);
         #5;
         n++;
      end
      if (irq_o !== val) begin
         $display("timeout waiting for irq to reach %0d", val);
         timeouts++;
      end
   endtask

   function automatic logic [15:0] go_word(input logic [3:0] cmd, input logic ie_set);
      logic [15:0] w;
      w = 16'h0000;
      w[CSR_GO_BIT]         = 1'b1;
      w[CSR_CMD_LSB +: 4]   = cmd;
      w[CSR_IE_BIT]         = ie_set;
      w[CSR_EXT_LSB +: 6]   = EXT_ADR;
      return w;
   endfunction

   // error/status word as the host sees it on dr
   function automatic logic [15:0] status_word(input logic ecyl, input logic esec,
                                              input logic nxp, input logic [1:0] drv,
                                              input logic hd);
      logic [15:0] w;
      w       = 16'h0004;
      w[4]    = ecyl;
      w[5]    = esec;
      w[9:8]  = drv;
      w[10]   = hd;
      w[11]   = nxp;
      return w;
   endfunction

   // go, parm address through dr, then wait for done
   task automatic run_locate(input logic [3:0] cmd, input logic ie_set, input logic [1:0] drv,
                             input logic hd, input logic [6:0] cyl, input logic [3:0] sec);
      mem[PARM_ADR[8:1]]         = {13'd0, hd, drv};
      mem[PARM_ADR[8:1] + 8'd2]  = {1'b0, cyl, 4'd0, sec};   // sector one-based
      adr_q.delete();
      bus_write(CSR, go_word(cmd, ie_set));
      poll_csr(CSR_DRQ_BIT, 1'b1, "drq");
      bus_write(DR, PARM_ADR);
      poll_csr(CSR_DONE_BIT, 1'b1, "done");
   endtask

   initial begin
      logic [15:0] rd;
      logic [26:0] blk_prev;
      errors         = 0;
      timeouts       = 0;
      req_cnt        = 0;
      irq_cnt        = 0;
      ack_wait       = 0;
      no_ack         = 1'b0;
      req_q          = 1'b0;
      ack_busy       = 1'b0;
      wb_rst_i       = 1'b1;
      wb_adr_i       = 2'b00;
      wb_dat_i       = 16'h0000;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      wb_we_i        = 1'b0;
      wb_sel_i       = 2'b11;
      iack_i         = 1'b0;
      dma_gnt_i      = 1'b0;
      dma_ack_i      = 1'b0;
      dma_dat_i      = 16'h0000;
      start_offset_i = 27'h4d2a5f3;
      for (int i = 0; i < 256; i++) mem[i] = 16'(i * 16'h0123) ^ 16'h5a5a;
      repeat (5) @(posedge wb_clk_i);
      #5;
      wb_rst_i = 1'b0;

      // state after reset, done only
      bus_read(CSR, rd);
      check("csr", 32'(rd & 16'h80e0), 32'h0020);
      check("irq_o", 32'(irq_o), 32'h0);
      check("dma_req_o", 32'(dma_req_o), 32'h0);

      // read, drive 2 head 1 cyl 12 sector 4, interrupt on
      run_locate(CMD_RD, 1'b1, 2'd2, 1'b1, 7'd12, 4'd4);
      check("dma fetches", 32'(adr_q.size()), 32'd2);
      check("dma_adr_o word 0", 32'(adr_q[0]), 32'({EXT_ADR, PARM_ADR}));
      check("dma_adr_o word 2", 32'(adr_q[1]), 32'({EXT_ADR, PARM_ADR + 16'd4}));
      wait_irq(1'b1);
      iack_i = 1'b1;
      wait_irq(1'b0);
      iack_i = 1'b0;
      check("sd_block_o", 32'(sd_block_o),
            32'({start_offset_i[26:13], 2'd2, 11'(12 * 20 + 10 + 3)}));
      bus_read(DR, rd);
      check("status", 32'(rd), 32'(status_word(1'b0, 1'b0, 1'b0, 2'd2, 1'b1)));

      // cylinder out of range, block address kept
      blk_prev = sd_block_o;
      run_locate(CMD_WR, 1'b0, 2'd1, 1'b0, 7'd85, 4'd2);
      bus_read(DR, rd);
      check("status[4]", 32'(rd[4]), 32'h1);
      bus_read(CSR, rd);
      check("csr[15]", 32'(rd[CSR_ERR_BIT]), 32'h1);
      check("sd_block_o", 32'(sd_block_o), 32'(blk_prev));

      // sector 11 too high, sector 0 wraps
      run_locate(CMD_RMD, 1'b0, 2'd0, 1'b1, 7'd3, 4'd11);
      bus_read(DR, rd);
      check("status[5]", 32'(rd[5]), 32'h1);
      run_locate(CMD_WRM, 1'b0, 2'd0, 1'b0, 7'd3, 4'd0);
      bus_read(DR, rd);
      check("status[5]", 32'(rd[5]), 32'h1);

      // host memory silent, fetch gives up
      no_ack = 1'b1;
      run_locate(CMD_RD, 1'b0, 2'd3, 1'b0, 7'd1, 4'd1);
      no_ack = 1'b0;
      bus_read(DR, rd);
      check("status[11]", 32'(rd[11]), 32'h1);

      // seek, no fetch and no interrupt
      req_cnt = 0;
      irq_cnt = 0;
      bus_write(CSR, go_word(CMD_SEEK, 1'b0));
      poll_csr(CSR_DRQ_BIT, 1'b1, "drq on seek");
      bus_write(DR, 16'h1234);
      poll_csr(CSR_DONE_BIT, 1'b1, "done on seek");
      check("dma_req_o cycles", 32'(req_cnt), 32'h0);
      check("irq_o cycles", 32'(irq_cnt), 32'h0);

      repeat (3) @(posedge wb_clk_i);
      $display("errors: %0d checks, %0d timeouts, %0d assertions", errors, timeouts,
               fdd_my_top_inst.fdd_my_assert_inst.fail_cnt);
      if (errors == 0 && timeouts == 0 && fdd_my_top_inst.fdd_my_assert_inst.fail_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== sources.f ====
hdl/fdd_my_pkg.sv
hdl/fdd_my_regs.sv
hdl/fdd_my_parm_fetch.sv
hdl/fdd_my_cmd_ctl.sv
hdl/fdd_my_top.sv
verification/fdd_my_assert.sv
verification/fdd_my_tb.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vfdd_my_tb: sources.f $(wildcard hdl/*.sv verification/*.sv)
	verilator --binary --timing --assert --top-module fdd_my_tb -f sources.f -o Vfdd_my_tb

run: obj_dir/Vfdd_my_tb
	./obj_dir/Vfdd_my_tb +verilator+error+limit+100 | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
